// ==== verilog/tt_buffer_pkg.sv ====
// shared constants and packed types for the time-tagging capture buffer
// covers sample and timestamp payloads, capture commands and readout beats

`default_nettype none

package tt_buffer_pkg;

  // adc sample format
  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 2;

  // readout bus width in bits
  localparam int READOUT_WIDTH = 64;

  // buffer sizes in entries
  localparam int SAMPLE_DEPTH = 32;
  localparam int TSTAMP_DEPTH = 16;

  // cycles from discriminator reset to hardware start
  localparam int DISC_LATENCY = 4;

  // one batch of parallel samples, sample 0 in the low bits
  typedef struct packed {
    logic [PARALLEL_SAMPLES-1:0][SAMPLE_WIDTH-1:0] sample;
  } sample_batch_t;

  // one timestamp, 16 bits total
  typedef struct packed {
    logic [3:0]  channel;
    logic [11:0] index;
  } tstamp_t;

  // software command strobe
  typedef struct packed {
    logic arm;
    logic start;
    logic stop;
    logic valid;
  } capture_cmd_t;

  // readout beat, ready travels back on its own wire
  typedef struct packed {
    logic [READOUT_WIDTH-1:0] data;
    logic                     last;
    logic                     valid;
  } readout_beat_t;

  typedef struct packed {
    sample_batch_t data;
    logic          valid;
  } sample_in_t;

  typedef struct packed {
    tstamp_t data;
    logic    valid;
  } tstamp_in_t;

endpackage

`default_nettype wire

// ==== verilog/capture_control.sv ====
// capture control for the two peer buffers
// decodes arm/start/stop strobes, delays start by the discriminator latency

`timescale 1ns/1ps
`default_nettype none

module capture_control import tt_buffer_pkg::*; (
  input  wire logic         ps_clk,
  input  wire logic         ps_reset,
  input  wire capture_cmd_t capture_cmd,
  input  wire logic         digital_trigger,
  input  wire logic         sample_full,
  input  wire logic         tstamp_full,
  output logic              arm,
  output logic              hw_start,
  output logic              sample_stop,
  output logic              tstamp_stop,
  output logic              discriminator_reset
);

  // registered software stop pulse
  logic sw_stop;

  // start or trigger, registered once
  logic start_req;

  // discriminator latency pipe
  logic [DISC_LATENCY-1:0] start_pipe;

  ////////////////////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      arm <= 1'b0;
      sw_stop <= 1'b0;
      start_req <= 1'b0;
    end else begin
      arm <= capture_cmd.valid && capture_cmd.arm;
      sw_stop <= capture_cmd.valid && capture_cmd.stop;
      // trigger level counts every cycle, buffers only react when armed
      start_req <= (capture_cmd.valid && capture_cmd.start) || digital_trigger;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // start delay
  ////////////////////////////////////////////////////////////////////////////

  // discriminator reset fires first, capture starts DISC_LATENCY later
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      start_pipe <= '0;
    end else begin
      start_pipe <= {start_pipe[DISC_LATENCY-2:0], start_req};
    end
  end

  assign discriminator_reset = start_req;
  assign hw_start = start_pipe[DISC_LATENCY-1];

  // a full buffer stops its peer
  assign sample_stop = sw_stop || tstamp_full;
  assign tstamp_stop = sw_stop || sample_full;

endmodule

`default_nettype wire

// ==== verilog/capture_buffer.sv ====
// capture buffer with its own memory
// stores items between hw start and stop, then streams the whole memory out

`timescale 1ns/1ps
`default_nettype none

module capture_buffer #(
  parameter type payload_t = logic [15:0],
  parameter int  DEPTH     = 16
) (
  input  wire logic                       ps_clk,
  input  wire logic                       ps_reset,
  input  wire payload_t                   in_data,
  input  wire logic                       in_valid,
  input  wire logic                       arm,
  input  wire logic                       hw_start,
  input  wire logic                       hw_stop,
  input  wire logic                       readout_start,
  output logic                            full,
  output logic [$clog2(DEPTH + 1)-1:0]    write_depth,
  output payload_t                        out_data,
  output logic                            out_valid,
  output logic                            out_last,
  input  wire logic                       out_ready
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  typedef enum logic [2:0] {IDLE, ARMED, CAPTURE, HOLD, READOUT} state_t;

  state_t        state;
  payload_t      mem [DEPTH];
  logic [CW-1:0] rd_cnt;
  logic          write_en;
  logic          rd_issue;

  // depth is registered so full lags the last write by one cycle
  assign full = (write_depth == CW'(DEPTH));

  // start cycle counts as capture, stop cycle does not
  assign write_en = in_valid && !hw_stop && !full
                    && ((state == CAPTURE) || (state == ARMED && hw_start));

  // read only when the output register is free or being drained
  assign rd_issue = (state == READOUT) && (rd_cnt != CW'(DEPTH))
                    && (!out_valid || out_ready);

  ////////////////////////////////////////////////////////////////////////////
  // capture fsm
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      state <= IDLE;
      write_depth <= '0;
    end else begin
      unique case (state)
        IDLE, HOLD: begin
          // re-arm drops the old depth, memory keeps stale data
          if (arm) begin
            state <= ARMED;
            write_depth <= '0;
          end else if (state == HOLD && readout_start) begin
            state <= READOUT;
          end
        end
        ARMED: begin
          if (hw_start) begin
            state <= hw_stop ? HOLD : CAPTURE;
          end
        end
        CAPTURE: begin
          if (hw_stop || full) begin
            state <= HOLD;
          end
        end
        READOUT: begin
          if (out_valid && out_ready && out_last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
      if (write_en) begin
        write_depth <= write_depth + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory and readout stream
  ////////////////////////////////////////////////////////////////////////////

  // write at the current depth, read into the held output register
  always_ff @(posedge ps_clk) begin
    if (write_en) begin
      mem[write_depth[AW-1:0]] <= in_data;
    end
    if (rd_issue) begin
      out_data <= mem[rd_cnt[AW-1:0]];
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      rd_cnt <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else if (state == HOLD && readout_start) begin
      rd_cnt <= '0;
    end else if (rd_issue) begin
      out_valid <= 1'b1;
      out_last <= (rd_cnt == CW'(DEPTH - 1));
      rd_cnt <= rd_cnt + 1'b1;
    end else if (out_ready) begin
      // drained with nothing left to read
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/readout_packer.sv ====
// packs consecutive payload words into readout beats
// first word lands in the low bits, last follows the final word

`timescale 1ns/1ps
`default_nettype none

module readout_packer import tt_buffer_pkg::*; #(
  parameter type payload_t = logic [15:0]
) (
  input  wire logic          ps_clk,
  input  wire logic          ps_reset,
  input  wire payload_t      in_data,
  input  wire logic          in_valid,
  input  wire logic          in_last,
  output logic               in_ready,
  output readout_beat_t      out,
  input  wire logic          out_ready
);

  localparam int W = $bits(payload_t);
  localparam int RATIO = READOUT_WIDTH / W;
  localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  // words collected so far, the final one goes straight into the beat
  logic [RATIO-2:0][W-1:0] words;
  logic [CNT_W-1:0]        cnt;
  logic                    accept;

  // stall the input while a beat sits unaccepted
  assign in_ready = !(out.valid && !out_ready);
  assign accept = in_valid && in_ready;

  // payload collection
  always_ff @(posedge ps_clk) begin
    if (accept && cnt != CNT_W'(RATIO - 1)) begin
      words[cnt] <= in_data;
    end
    if (accept && cnt == CNT_W'(RATIO - 1)) begin
      out.data <= {in_data, words};
    end
  end

  // word count and beat handshake
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      cnt <= '0;
      out.valid <= 1'b0;
      out.last <= 1'b0;
    end else begin
      if (out_ready) begin
        out.valid <= 1'b0;
      end
      if (accept) begin
        if (cnt == CNT_W'(RATIO - 1)) begin
          cnt <= '0;
          out.valid <= 1'b1;
          out.last <= in_last;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/readout_sequencer.sv ====
// merges timestamp beats then sample beats onto one readout port
// last goes out only with the final sample beat

`timescale 1ns/1ps
`default_nettype none

module readout_sequencer import tt_buffer_pkg::*; (
  input  wire logic          ps_clk,
  input  wire logic          ps_reset,
  input  wire readout_beat_t tstamp_beats,
  output logic               tstamp_ready,
  input  wire readout_beat_t sample_beats,
  output logic               sample_ready,
  output readout_beat_t      readout,
  input  wire logic          readout_ready
);

  typedef enum logic {SEL_TSTAMP, SEL_SAMPLE} sel_t;

  sel_t sel;

  // flip after the selected stream's last beat transfers
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      sel <= SEL_TSTAMP;
    end else begin
      unique case (sel)
        SEL_TSTAMP: begin
          if (tstamp_beats.valid && tstamp_beats.last && readout_ready) begin
            sel <= SEL_SAMPLE;
          end
        end
        SEL_SAMPLE: begin
          if (sample_beats.valid && sample_beats.last && readout_ready) begin
            sel <= SEL_TSTAMP;
          end
        end
        default: sel <= SEL_TSTAMP;
      endcase
    end
  end

  // zero latency pass-through
  always_comb begin
    if (sel == SEL_SAMPLE) begin
      readout = sample_beats;
    end else begin
      readout = tstamp_beats;
      // timestamps are only the first part of the run
      readout.last = 1'b0;
    end
  end

  // ready goes only to the selected source
  assign tstamp_ready = (sel == SEL_TSTAMP) && readout_ready;
  assign sample_ready = (sel == SEL_SAMPLE) && readout_ready;

endmodule

`default_nettype wire

// ==== verilog/timetagging_sample_buffer.sv ====
// time-tagging sample buffer top level
// two peer capture buffers sharing start/stop, read out as one beat stream

`timescale 1ns/1ps
`default_nettype none

module timetagging_sample_buffer import tt_buffer_pkg::*; (
  input  wire logic                              ps_clk,
  input  wire logic                              ps_reset,
  input  wire sample_in_t                        samples_in,
  input  wire tstamp_in_t                        tstamps_in,
  input  wire capture_cmd_t                      capture_cmd,
  input  wire logic                              digital_trigger,
  output logic                                   discriminator_reset,
  input  wire logic                              readout_start,
  output logic [$clog2(SAMPLE_DEPTH + 1)-1:0]    samples_write_depth,
  output logic [$clog2(TSTAMP_DEPTH + 1)-1:0]    tstamps_write_depth,
  output readout_beat_t                          readout,
  input  wire logic                              readout_ready
);

  // control to buffers
  logic arm;
  logic hw_start;
  logic sample_stop;
  logic tstamp_stop;
  logic sample_full;
  logic tstamp_full;

  // buffer word streams
  tstamp_t       tstamp_word;
  logic          tstamp_word_valid;
  logic          tstamp_word_last;
  logic          tstamp_word_ready;
  sample_batch_t sample_word;
  logic          sample_word_valid;
  logic          sample_word_last;
  logic          sample_word_ready;

  // packed beat streams
  readout_beat_t tstamp_beats;
  readout_beat_t sample_beats;
  logic          tstamp_beats_ready;
  logic          sample_beats_ready;

  ////////////////////////////////////////////////////////////////////////////
  // capture control
  ////////////////////////////////////////////////////////////////////////////

  capture_control i_capture_control (
    .ps_clk              (ps_clk),
    .ps_reset            (ps_reset),
    .capture_cmd         (capture_cmd),
    .digital_trigger     (digital_trigger),
    .sample_full         (sample_full),
    .tstamp_full         (tstamp_full),
    .arm                 (arm),
    .hw_start            (hw_start),
    .sample_stop         (sample_stop),
    .tstamp_stop         (tstamp_stop),
    .discriminator_reset (discriminator_reset)
  );

  ////////////////////////////////////////////////////////////////////////////
  // buffers
  ////////////////////////////////////////////////////////////////////////////

  capture_buffer #(
    .payload_t (tstamp_t),
    .DEPTH     (TSTAMP_DEPTH)
  ) i_tstamp_buffer (
    .ps_clk        (ps_clk),
    .ps_reset      (ps_reset),
    .in_data       (tstamps_in.data),
    .in_valid      (tstamps_in.valid),
    .arm           (arm),
    .hw_start      (hw_start),
    .hw_stop       (tstamp_stop),
    .readout_start (readout_start),
    .full          (tstamp_full),
    .write_depth   (tstamps_write_depth),
    .out_data      (tstamp_word),
    .out_valid     (tstamp_word_valid),
    .out_last      (tstamp_word_last),
    .out_ready     (tstamp_word_ready)
  );

  capture_buffer #(
    .payload_t (sample_batch_t),
    .DEPTH     (SAMPLE_DEPTH)
  ) i_sample_buffer (
    .ps_clk        (ps_clk),
    .ps_reset      (ps_reset),
    .in_data       (samples_in.data),
    .in_valid      (samples_in.valid),
    .arm           (arm),
    .hw_start      (hw_start),
    .hw_stop       (sample_stop),
    .readout_start (readout_start),
    .full          (sample_full),
    .write_depth   (samples_write_depth),
    .out_data      (sample_word),
    .out_valid     (sample_word_valid),
    .out_last      (sample_word_last),
    .out_ready     (sample_word_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // readout path
  ////////////////////////////////////////////////////////////////////////////

  readout_packer #(
    .payload_t (tstamp_t)
  ) i_tstamp_packer (
    .ps_clk    (ps_clk),
    .ps_reset  (ps_reset),
    .in_data   (tstamp_word),
    .in_valid  (tstamp_word_valid),
    .in_last   (tstamp_word_last),
    .in_ready  (tstamp_word_ready),
    .out       (tstamp_beats),
    .out_ready (tstamp_beats_ready)
  );

  readout_packer #(
    .payload_t (sample_batch_t)
  ) i_sample_packer (
    .ps_clk    (ps_clk),
    .ps_reset  (ps_reset),
    .in_data   (sample_word),
    .in_valid  (sample_word_valid),
    .in_last   (sample_word_last),
    .in_ready  (sample_word_ready),
    .out       (sample_beats),
    .out_ready (sample_beats_ready)
  );

  // timestamps first, then samples
  readout_sequencer i_readout_sequencer (
    .ps_clk        (ps_clk),
    .ps_reset      (ps_reset),
    .tstamp_beats  (tstamp_beats),
    .tstamp_ready  (tstamp_beats_ready),
    .sample_beats  (sample_beats),
    .sample_ready  (sample_beats_ready),
    .readout       (readout),
    .readout_ready (readout_ready)
  );

endmodule

`default_nettype wire

// ==== include/tt_buffer_tb_ref.svh ====
// reference model for the time-tagging buffer testbench
// picks stored items out of the drive log and packs them into readout beats

`ifndef TT_BUFFER_TB_REF_SVH
`define TT_BUFFER_TB_REF_SVH

  // beat geometry
  localparam int TS_W = $bits(tstamp_t);
  localparam int SB_W = $bits(sample_batch_t);
  localparam int TS_PER_BEAT = READOUT_WIDTH / TS_W;
  localparam int SB_PER_BEAT = READOUT_WIDTH / SB_W;
  localparam int TS_BEATS = TSTAMP_DEPTH / TS_PER_BEAT;
  localparam int NUM_BEATS = TS_BEATS + SAMPLE_DEPTH / SB_PER_BEAT;

  // expected buffer contents after one capture
  tstamp_t       exp_tstamp [TSTAMP_DEPTH];
  sample_batch_t exp_sample [SAMPLE_DEPTH];
  int            exp_tstamp_depth;
  int            exp_sample_depth;

  // walk the log from the hw start cycle
  // stop_cyc is the first cycle the software stop is high
  function automatic void select_items(input int start_cyc, input int stop_cyc);
    int s_cnt;
    int t_cnt;
    bit s_done;
    bit t_done;
    bit s_full;
    bit t_full;
    bit sw;
    int c;
    s_cnt = 0;
    t_cnt = 0;
    s_done = 1'b0;
    t_done = 1'b0;
    c = start_cyc;
    while (!(s_done && t_done) && c < LOG_LEN) begin
      // full flags come from the depth registered in earlier cycles
      s_full = (s_cnt == SAMPLE_DEPTH);
      t_full = (t_cnt == TSTAMP_DEPTH);
      sw = (c >= stop_cyc);
      // each full flag stops the peer buffer
      if (!s_done) begin
        if (sw || t_full || s_full) begin
          s_done = 1'b1;
        end else begin
          exp_sample[s_cnt] = sample_log[c];
          s_cnt++;
        end
      end
      if (!t_done) begin
        if (sw || s_full || t_full) begin
          t_done = 1'b1;
        end else if (tstamp_vld_log[c]) begin
          exp_tstamp[t_cnt] = tstamp_log[c];
          t_cnt++;
        end
      end
      c++;
    end
    exp_sample_depth = s_cnt;
    exp_tstamp_depth = t_cnt;
  endfunction

  // beat k, timestamps first, first word in the low bits
  function automatic logic [READOUT_WIDTH-1:0] expected_beat(input int k);
    logic [READOUT_WIDTH-1:0] beat;
    int j;
    beat = '0;
    for (j = 0; j < TS_PER_BEAT && k < TS_BEATS; j++) begin
      beat[j*TS_W +: TS_W] = exp_tstamp[k * TS_PER_BEAT + j];
    end
    for (j = 0; j < SB_PER_BEAT && k >= TS_BEATS; j++) begin
      beat[j*SB_W +: SB_W] = exp_sample[(k - TS_BEATS) * SB_PER_BEAT + j];
    end
    return beat;
  endfunction

  // bits of beat k that hold entries below the write depth
  function automatic logic [READOUT_WIDTH-1:0] expected_mask(input int k);
    logic [READOUT_WIDTH-1:0] mask;
    int j;
    mask = '0;
    for (j = 0; j < TS_PER_BEAT && k < TS_BEATS; j++) begin
      if (k * TS_PER_BEAT + j < exp_tstamp_depth) begin
        mask[j*TS_W +: TS_W] = '1;
      end
    end
    for (j = 0; j < SB_PER_BEAT && k >= TS_BEATS; j++) begin
      if ((k - TS_BEATS) * SB_PER_BEAT + j < exp_sample_depth) begin
        mask[j*SB_W +: SB_W] = '1;
      end
    end
    return mask;
  endfunction

`endif

// ==== dv/tt_buffer_tb.sv ====
// testbench for the time-tagging sample buffer
// runs capture scenarios and checks depths and readout beats against a model

`timescale 1ns/1ps
`default_nettype none

module tt_buffer_tb import tt_buffer_pkg::*; ();

  // four scenarios of roughly 600 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int LOG_LEN = TIMEOUT_CYCLES + 8;
  localparam int NO_STOP = LOG_LEN;

  logic                                ps_clk;
  logic                                ps_reset;
  sample_in_t                          samples_in;
  tstamp_in_t                          tstamps_in;
  capture_cmd_t                        capture_cmd;
  logic                                digital_trigger;
  logic                                discriminator_reset;
  logic                                readout_start;
  logic [$clog2(SAMPLE_DEPTH + 1)-1:0] samples_write_depth;
  logic [$clog2(TSTAMP_DEPTH + 1)-1:0] tstamps_write_depth;
  readout_beat_t                       readout;
  logic                                readout_ready;

  integer seed = 32'h6901;
  int     cyc;

  // drive log, one entry per cycle
  sample_batch_t sample_log [LOG_LEN];
  tstamp_t       tstamp_log [LOG_LEN];
  logic          tstamp_vld_log [LOG_LEN];

  // readout checker state
  logic expect_readout;
  logic readout_done;
  int   beat_idx;

  `include "tt_buffer_tb_ref.svh"

  timetagging_sample_buffer i_timetagging_sample_buffer (
    .ps_clk              (ps_clk),
    .ps_reset            (ps_reset),
    .samples_in          (samples_in),
    .tstamps_in          (tstamps_in),
    .capture_cmd         (capture_cmd),
    .digital_trigger     (digital_trigger),
    .discriminator_reset (discriminator_reset),
    .readout_start       (readout_start),
    .samples_write_depth (samples_write_depth),
    .tstamps_write_depth (tstamps_write_depth),
    .readout             (readout),
    .readout_ready       (readout_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // clock, cycle count, watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ps_clk = 1'b0;
    forever #2 ps_clk = ~ps_clk;
  end

  initial begin
    cyc = 0;
    forever begin
      @(posedge ps_clk);
      cyc = cyc + 1;
    end
  end

  initial begin
    wait (cyc >= TIMEOUT_CYCLES);
    $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    $display(">>> FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s (at %0t)", what, $time);
    $display(">>> FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // data sources and dma sink ready
  ////////////////////////////////////////////////////////////////////////////

  // all random draws in one process keep the sequence fixed
  initial begin : drive_inputs
    int n_tstamp;
    samples_in = '0;
    tstamps_in = '0;
    readout_ready = 1'b0;
    n_tstamp = 0;
    forever begin
      @(posedge ps_clk);
      #1;
      // samples every cycle, two consecutive counts per batch
      samples_in.valid = 1'b1;
      samples_in.data.sample[0] = 16'(2 * cyc);
      samples_in.data.sample[1] = 16'(2 * cyc + 1);
      // timestamps on about one cycle in four
      tstamps_in.valid = (($random(seed) & 3) == 0);
      tstamps_in.data.index = 12'(n_tstamp);
      tstamps_in.data.channel = 4'(cyc);
      if (tstamps_in.valid) begin
        n_tstamp++;
      end
      readout_ready = (($random(seed) & 3) != 0);
      if (cyc < LOG_LEN) begin
        sample_log[cyc] = samples_in.data;
        tstamp_log[cyc] = tstamps_in.data;
        tstamp_vld_log[cyc] = tstamps_in.valid;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readout comparison
  ////////////////////////////////////////////////////////////////////////////

  // mid-cycle sampling, a beat moves at the next edge
  initial begin : check_readout
    logic [READOUT_WIDTH-1:0] mask;
    logic [READOUT_WIDTH-1:0] exp_data;
    forever begin
      @(negedge ps_clk);
      if (readout.valid && readout_ready) begin
        assert (expect_readout)
          else report_failure("readout beat delivered with no readout in progress");
        mask = expected_mask(beat_idx);
        exp_data = expected_beat(beat_idx);
        // stale entries above the depth are skipped
        check_value("readout.data", readout.data & mask, exp_data & mask);
        check_value("readout.last", readout.last, beat_idx == NUM_BEATS - 1);
        beat_idx++;
        if (readout.last) begin
          expect_readout = 1'b0;
          readout_done = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // negedge of the first cycle at or after n
  task automatic wait_for_cycle(input int n);
    do begin
      @(negedge ps_clk);
    end while (cyc < n);
  endtask

  task automatic send_cmd(input logic arm, input logic start, input logic stop,
                          output int cmd_cyc);
    @(posedge ps_clk);
    #1;
    capture_cmd.arm = arm;
    capture_cmd.start = start;
    capture_cmd.stop = stop;
    capture_cmd.valid = 1'b1;
    cmd_cyc = cyc;
    @(posedge ps_clk);
    #1;
    capture_cmd = '0;
  endtask

  task automatic pulse_trigger(output int trig_cyc);
    @(posedge ps_clk);
    #1;
    digital_trigger = 1'b1;
    trig_cyc = cyc;
    @(posedge ps_clk);
    #1;
    digital_trigger = 1'b0;
  endtask

  task automatic pulse_readout_start();
    @(posedge ps_clk);
    #1;
    readout_start = 1'b1;
    @(posedge ps_clk);
    #1;
    readout_start = 1'b0;
  endtask

  // one cycle wide, one cycle after the request
  task automatic check_disc_pulse(input int req_cyc);
    wait_for_cycle(req_cyc + 1);
    check_value("discriminator_reset", discriminator_reset, 1'b1);
    wait_for_cycle(req_cyc + 2);
    check_value("discriminator_reset", discriminator_reset, 1'b0);
  endtask

  // the peer stops one cycle after either buffer fills
  task automatic wait_for_full();
    do begin
      @(negedge ps_clk);
    end while (samples_write_depth != SAMPLE_DEPTH && tstamps_write_depth != TSTAMP_DEPTH);
    wait_for_cycle(cyc + 2);
  endtask

  task automatic check_depths();
    check_value("samples_write_depth", samples_write_depth, exp_sample_depth);
    check_value("tstamps_write_depth", tstamps_write_depth, exp_tstamp_depth);
  endtask

  // later beats trip the no-readout check, so last shows up only once
  task automatic run_readout();
    beat_idx = 0;
    readout_done = 1'b0;
    expect_readout = 1'b1;
    pulse_readout_start();
    wait (readout_done);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    int t;
    int g;
    int s;
    int keep_s;
    int keep_t;
    ps_reset = 1'b1;
    capture_cmd = '0;
    digital_trigger = 1'b0;
    readout_start = 1'b0;
    expect_readout = 1'b0;
    readout_done = 1'b0;
    beat_idx = 0;
    repeat (8) @(posedge ps_clk);
    #1;
    ps_reset = 1'b0;

    // idle after reset, a readout request finds nothing
    wait_for_cycle(cyc + 1);
    check_value("discriminator_reset", discriminator_reset, 1'b0);
    check_value("readout.valid", readout.valid, 1'b0);
    check_value("readout.last", readout.last, 1'b0);
    check_value("samples_write_depth", samples_write_depth, 0);
    check_value("tstamps_write_depth", tstamps_write_depth, 0);
    pulse_readout_start();
    wait_for_cycle(cyc + 20);

    // software arm and start, sample buffer fills first
    send_cmd(1'b1, 1'b1, 1'b0, t);
    check_disc_pulse(t);
    wait_for_full();
    select_items(t + 1 + DISC_LATENCY, NO_STOP);
    check_value("samples_write_depth", samples_write_depth, SAMPLE_DEPTH);
    check_depths();
    run_readout();

    // arm, hardware trigger, then software stop
    send_cmd(1'b1, 1'b0, 1'b0, t);
    wait_for_cycle(t + 4);
    pulse_trigger(g);
    check_disc_pulse(g);
    // first write lands in the hw start cycle
    wait_for_cycle(g + DISC_LATENCY + 1);
    check_value("samples_write_depth", samples_write_depth, 0);
    wait_for_cycle(g + DISC_LATENCY + 2);
    check_value("samples_write_depth", samples_write_depth, 1);
    wait_for_cycle(g + DISC_LATENCY + 20);
    send_cmd(1'b0, 1'b0, 1'b1, s);
    wait_for_cycle(s + 3);
    select_items(g + 1 + DISC_LATENCY, s + 1);
    check_depths();
    run_readout();

    // trigger with nothing armed
    keep_s = samples_write_depth;
    keep_t = tstamps_write_depth;
    pulse_trigger(g);
    check_disc_pulse(g);
    wait_for_cycle(g + DISC_LATENCY + 4);
    check_value("samples_write_depth", samples_write_depth, keep_s);
    check_value("tstamps_write_depth", tstamps_write_depth, keep_t);
    pulse_readout_start();
    wait_for_cycle(cyc + 20);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/tt_buffer_pkg.sv
verilog/capture_control.sv
verilog/capture_buffer.sv
verilog/readout_packer.sv
verilog/readout_sequencer.sv
verilog/timetagging_sample_buffer.sv
dv/tt_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: timetagging_sample_buffer

sources:
  - files:
      - verilog/tt_buffer_pkg.sv
      - verilog/capture_control.sv
      - verilog/capture_buffer.sv
      - verilog/readout_packer.sv
      - verilog/readout_sequencer.sv
      - verilog/timetagging_sample_buffer.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tt_buffer_tb.sv
